// File: id_config.svh
// Decode stage configuration

`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Data path and PC width
`define XLEN 32

// Register index width, 32 integer registers
`define REG_ADDR_W 5

// ADDI x0,x0,0 held in the ID/EX register after reset
`define ID_NOP_INSTR 32'h0000_0013

`endif

// File: rv_isa_pkg.sv
// RV32I instruction encodings

package rv_isa_pkg;

  // Major opcodes of the base integer ISA
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Field views of one instruction word, MSB first
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } rv_instr_u;

endpackage

// File: id_ctrl_pkg.sv
// Decoded control types

package id_ctrl_pkg;

  // ALU operators, compares last for branches
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_sel_e;

  // Same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_type_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LSU,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    logic      rf_we;
    wb_sel_e   wb_sel;
    logic      lsu_req;
    logic      lsu_we;
    lsu_type_e lsu_type;
    logic      lsu_sign_ext;
    logic      branch;
    logic      jump;
    logic      illegal;
    logic      ecall;
    logic      ebreak;
  } id_ctrl_t;

endpackage

// File: id_dec_if.sv
// Decoder output bundle
`timescale 1ns/100ps
`include "id_config.svh"

interface id_dec_if import id_ctrl_pkg::*; ();

  id_ctrl_t                ctrl;
  imm_sel_e                imm_sel;
  logic [`REG_ADDR_W-1:0]  rd_addr;
  logic [`REG_ADDR_W-1:0]  rs1_addr;   // Also feeds the register file ports
  logic [`REG_ADDR_W-1:0]  rs2_addr;

  modport dec (
    output ctrl,
    output imm_sel,
    output rd_addr,
    output rs1_addr,
    output rs2_addr
  );

  modport imm (
    input imm_sel
  );

  modport pipe (
    input ctrl,
    input rd_addr
  );

endinterface

// File: id_decoder.sv
// RV32I control decoder
`timescale 1ns/100ps

module id_decoder import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  rv_instr_u instr_i,
  id_dec_if.dec     dec
);

  id_ctrl_t   ctrl_d;
  imm_sel_e   imm_sel_d;
  logic       illegal;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;   // Upper immediate bits for shifts by constant

  always_comb begin
    ctrl_d = '{
      alu_op:   ALU_ADD,
      op_a_sel: OP_A_REG,
      op_b_sel: OP_B_REG,
      wb_sel:   WB_ALU,
      lsu_type: LSU_WORD,
      default:  1'b0
    };
    imm_sel_d = IMM_I;
    illegal   = 1'b0;

    case (instr_i.r.opcode)
      OPC_LUI: begin
        ctrl_d.op_a_sel = OP_A_ZERO;
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        imm_sel_d       = IMM_U;
      end
      OPC_AUIPC: begin
        ctrl_d.op_a_sel = OP_A_PC;
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        imm_sel_d       = IMM_U;
      end
      OPC_JAL: begin
        ctrl_d.op_a_sel = OP_A_PC;    // ALU forms the target
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        ctrl_d.wb_sel   = WB_PC4;
        ctrl_d.jump     = 1'b1;
        imm_sel_d       = IMM_J;
      end
      OPC_JALR: begin
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        ctrl_d.wb_sel   = WB_PC4;
        ctrl_d.jump     = 1'b1;
        illegal         = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl_d.branch = 1'b1;
        imm_sel_d     = IMM_B;
        case (funct3)
          3'b000:  ctrl_d.alu_op = ALU_EQ;
          3'b001:  ctrl_d.alu_op = ALU_NE;
          3'b100:  ctrl_d.alu_op = ALU_LT;
          3'b101:  ctrl_d.alu_op = ALU_GE;
          3'b110:  ctrl_d.alu_op = ALU_LTU;
          3'b111:  ctrl_d.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl_d.op_b_sel     = OP_B_IMM;
        ctrl_d.rf_we        = 1'b1;
        ctrl_d.wb_sel       = WB_LSU;
        ctrl_d.lsu_req      = 1'b1;
        ctrl_d.lsu_type     = lsu_type_e'(funct3[1:0]);
        ctrl_d.lsu_sign_ext = ~funct3[2];   // LBU and LHU zero-extend
        illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.lsu_req  = 1'b1;
        ctrl_d.lsu_we   = 1'b1;
        ctrl_d.lsu_type = lsu_type_e'(funct3[1:0]);
        imm_sel_d       = IMM_S;
        illegal         = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP_IMM: begin
        ctrl_d.op_b_sel = OP_B_IMM;
        ctrl_d.rf_we    = 1'b1;
        case (funct3)
          3'b000: ctrl_d.alu_op = ALU_ADD;
          3'b010: ctrl_d.alu_op = ALU_SLT;
          3'b011: ctrl_d.alu_op = ALU_SLTU;
          3'b100: ctrl_d.alu_op = ALU_XOR;
          3'b110: ctrl_d.alu_op = ALU_OR;
          3'b111: ctrl_d.alu_op = ALU_AND;
          3'b001: begin
            ctrl_d.alu_op = ALU_SLL;
            illegal       = (funct7 != 7'b0000000);
          end
          default: begin               // SRLI and SRAI
            ctrl_d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal       = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPC_OP: begin
        ctrl_d.rf_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl_d.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_d.alu_op = ALU_SUB;
          10'b0000000_001: ctrl_d.alu_op = ALU_SLL;
          10'b0000000_010: ctrl_d.alu_op = ALU_SLT;
          10'b0000000_011: ctrl_d.alu_op = ALU_SLTU;
          10'b0000000_100: ctrl_d.alu_op = ALU_XOR;
          10'b0000000_101: ctrl_d.alu_op = ALU_SRL;
          10'b0100000_101: ctrl_d.alu_op = ALU_SRA;
          10'b0000000_110: ctrl_d.alu_op = ALU_OR;
          10'b0000000_111: ctrl_d.alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_MISC_MEM: begin
        // In-order core with no caches, FENCE does nothing
        illegal = (funct3 != 3'b000);
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000 && instr_i.i.rs1 == '0 && instr_i.i.rd == '0) begin
          case (instr_i.i.imm_11_0)
            12'h000: ctrl_d.ecall  = 1'b1;
            12'h001: ctrl_d.ebreak = 1'b1;
            default: illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words still travel down, but change no state
    ctrl_d.illegal = illegal;
    if (illegal) begin
      ctrl_d.rf_we   = 1'b0;
      ctrl_d.lsu_req = 1'b0;
    end
  end

  assign dec.ctrl     = ctrl_d;
  assign dec.imm_sel  = imm_sel_d;
  assign dec.rd_addr  = instr_i.r.rd;
  assign dec.rs1_addr = instr_i.r.rs1;
  assign dec.rs2_addr = instr_i.r.rs2;

endmodule

// File: id_imm_gen.sv
// Immediate generator
`timescale 1ns/100ps
`include "id_config.svh"

module id_imm_gen import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  rv_instr_u        instr_i,
  id_dec_if.imm            dec,
  output logic [`XLEN-1:0] imm_o
);

  // Bit 31 of the word is the sign in every format
  always_comb begin
    case (dec.imm_sel)
      IMM_S: begin
        imm_o = {{(`XLEN-11){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5[5:0],
                 instr_i.s.imm_4_0};
      end
      IMM_B: begin
        imm_o = {{(`XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                 instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
      end
      IMM_U: begin
        imm_o = {{(`XLEN-31){instr_i.u.imm_31_12[19]}}, instr_i.u.imm_31_12[18:0],
                 12'b0};
      end
      IMM_J: begin
        imm_o = {{(`XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                 instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
      end
      default: begin             // I format
        imm_o = {{(`XLEN-11){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0[10:0]};
      end
    endcase
  end

endmodule

// File: id_ex_pipe.sv
// ID/EX pipeline register
`timescale 1ns/100ps
`include "id_config.svh"

module id_ex_pipe import id_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  id_dec_if.pipe                 dec,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic [`XLEN-1:0]       imm_i,
  output logic                   ex_valid_o,
  input  logic                   ex_ready_i,
  output id_ctrl_t               ex_ctrl_o,
  output logic [`XLEN-1:0]       ex_pc_o,
  output logic [`XLEN-1:0]       ex_rs1_data_o,
  output logic [`XLEN-1:0]       ex_rs2_data_o,
  output logic [`XLEN-1:0]       ex_imm_o,
  output logic [`REG_ADDR_W-1:0] ex_rd_o
);

  localparam logic [31:0] NopInstr = `ID_NOP_INSTR;

  // Control of the NOP; writing x0 is a no-op so rf_we stays low
  localparam id_ctrl_t NopCtrl = '{
    alu_op:   ALU_ADD,
    op_a_sel: OP_A_REG,
    op_b_sel: OP_B_IMM,
    wb_sel:   WB_ALU,
    lsu_type: LSU_WORD,
    default:  1'b0
  };

  logic valid_q;
  logic load;

  // Single slot, refilled in the cycle it drains
  assign in_ready_o = ~valid_q | ex_ready_i;
  assign load       = in_valid_i & in_ready_o;

  ////////////////////////////////////////////////////////////
  // Control and valid
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      ex_ctrl_o <= NopCtrl;
      ex_rd_o   <= NopInstr[11:7];
      ex_imm_o  <= {{(`XLEN-11){NopInstr[31]}}, NopInstr[30:20]};
    end else begin
      if (in_ready_o) begin
        valid_q <= in_valid_i;
      end
      if (load) begin
        ex_ctrl_o <= dec.ctrl;
        ex_rd_o   <= dec.rd_addr;
        ex_imm_o  <= imm_i;
      end
    end
  end

  // Operands, captured with the instruction
  always_ff @(posedge clk_i) begin
    if (load) begin
      ex_pc_o       <= pc_i;
      ex_rs1_data_o <= rs1_data_i;
      ex_rs2_data_o <= rs2_data_i;
    end
  end

  assign ex_valid_o = valid_q;

endmodule

// File: id_stage.sv
// Instruction decode stage
`timescale 1ns/100ps
`include "id_config.svh"

module id_stage import id_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Fetch side
  input  logic                   instr_valid_i,
  output logic                   instr_ready_o,
  input  logic [`XLEN-1:0]       instr_i,
  input  logic [`XLEN-1:0]       pc_i,

  // Register file, asynchronous read
  output logic [`REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [`REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [`XLEN-1:0]       rf_rdata_a_i,
  input  logic [`XLEN-1:0]       rf_rdata_b_i,

  // Execute side
  output logic                   ex_valid_o,
  input  logic                   ex_ready_i,
  output logic [`XLEN-1:0]       ex_pc_o,
  output logic [`XLEN-1:0]       ex_rs1_data_o,
  output logic [`XLEN-1:0]       ex_rs2_data_o,
  output logic [`XLEN-1:0]       ex_imm_o,
  output logic [`REG_ADDR_W-1:0] ex_rd_o,
  output alu_op_e                ex_alu_op_o,
  output op_a_sel_e              ex_op_a_sel_o,
  output op_b_sel_e              ex_op_b_sel_o,
  output logic                   ex_rf_we_o,
  output wb_sel_e                ex_wb_sel_o,
  output logic                   ex_lsu_req_o,
  output logic                   ex_lsu_we_o,
  output lsu_type_e              ex_lsu_type_o,
  output logic                   ex_lsu_sign_ext_o,
  output logic                   ex_branch_o,
  output logic                   ex_jump_o,
  output logic                   ex_illegal_o,
  output logic                   ex_ecall_o,
  output logic                   ex_ebreak_o
);

  id_dec_if dec_bus ();

  logic [`XLEN-1:0] imm;
  id_ctrl_t         ex_ctrl;

  id_decoder u_decoder (
    .instr_i (instr_i),
    .dec     (dec_bus.dec)
  );

  id_imm_gen u_imm_gen (
    .instr_i (instr_i),
    .dec     (dec_bus.imm),
    .imm_o   (imm)
  );

  // Read addresses straight from the incoming word
  assign rf_raddr_a_o = dec_bus.rs1_addr;
  assign rf_raddr_b_o = dec_bus.rs2_addr;

  id_ex_pipe u_ex_pipe (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (instr_valid_i),
    .in_ready_o    (instr_ready_o),
    .dec           (dec_bus.pipe),
    .pc_i          (pc_i),
    .rs1_data_i    (rf_rdata_a_i),
    .rs2_data_i    (rf_rdata_b_i),
    .imm_i         (imm),
    .ex_valid_o    (ex_valid_o),
    .ex_ready_i    (ex_ready_i),
    .ex_ctrl_o     (ex_ctrl),
    .ex_pc_o       (ex_pc_o),
    .ex_rs1_data_o (ex_rs1_data_o),
    .ex_rs2_data_o (ex_rs2_data_o),
    .ex_imm_o      (ex_imm_o),
    .ex_rd_o       (ex_rd_o)
  );

  ////////////////////////////////////////////////////////////
  // Registered control bundle to flat ports
  ////////////////////////////////////////////////////////////

  assign ex_alu_op_o       = ex_ctrl.alu_op;
  assign ex_op_a_sel_o     = ex_ctrl.op_a_sel;
  assign ex_op_b_sel_o     = ex_ctrl.op_b_sel;
  assign ex_rf_we_o        = ex_ctrl.rf_we;
  assign ex_wb_sel_o       = ex_ctrl.wb_sel;
  assign ex_lsu_req_o      = ex_ctrl.lsu_req;
  assign ex_lsu_we_o       = ex_ctrl.lsu_we;
  assign ex_lsu_type_o     = ex_ctrl.lsu_type;
  assign ex_lsu_sign_ext_o = ex_ctrl.lsu_sign_ext;
  assign ex_branch_o       = ex_ctrl.branch;
  assign ex_jump_o         = ex_ctrl.jump;
  assign ex_illegal_o      = ex_ctrl.illegal;
  assign ex_ecall_o        = ex_ctrl.ecall;
  assign ex_ebreak_o       = ex_ctrl.ebreak;

endmodule

// File: tb_id_stage.sv
// Decode stage testbench
`timescale 1ns/100ps
`include "id_config.svh"

module tb_id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; ();

  localparam int NumTests = 6;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid;
  logic                   instr_ready;
  logic [`XLEN-1:0]       instr;
  logic [`XLEN-1:0]       pc;
  logic [`REG_ADDR_W-1:0] rf_raddr_a;
  logic [`REG_ADDR_W-1:0] rf_raddr_b;
  logic [`XLEN-1:0]       rf_rdata_a;
  logic [`XLEN-1:0]       rf_rdata_b;
  logic                   ex_valid;
  logic                   ex_ready;
  logic [`XLEN-1:0]       ex_pc;
  logic [`XLEN-1:0]       ex_rs1_data;
  logic [`XLEN-1:0]       ex_rs2_data;
  logic [`XLEN-1:0]       ex_imm;
  logic [`REG_ADDR_W-1:0] ex_rd;
  alu_op_e                ex_alu_op;
  op_a_sel_e              ex_op_a_sel;
  op_b_sel_e              ex_op_b_sel;
  logic                   ex_rf_we;
  wb_sel_e                ex_wb_sel;
  logic                   ex_lsu_req;
  logic                   ex_lsu_we;
  lsu_type_e              ex_lsu_type;
  logic                   ex_lsu_sign_ext;
  logic                   ex_branch;
  logic                   ex_jump;
  logic                   ex_illegal;
  logic                   ex_ecall;
  logic                   ex_ebreak;

  int err_cnt;
  int pass_tests;
  int fail_tests;
  logic [`XLEN-1:0] seen_pc[$];   // PCs handed to EX, in order

  id_stage i_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .instr_valid_i     (instr_valid),
    .instr_ready_o     (instr_ready),
    .instr_i           (instr),
    .pc_i              (pc),
    .rf_raddr_a_o      (rf_raddr_a),
    .rf_raddr_b_o      (rf_raddr_b),
    .rf_rdata_a_i      (rf_rdata_a),
    .rf_rdata_b_i      (rf_rdata_b),
    .ex_valid_o        (ex_valid),
    .ex_ready_i        (ex_ready),
    .ex_pc_o           (ex_pc),
    .ex_rs1_data_o     (ex_rs1_data),
    .ex_rs2_data_o     (ex_rs2_data),
    .ex_imm_o          (ex_imm),
    .ex_rd_o           (ex_rd),
    .ex_alu_op_o       (ex_alu_op),
    .ex_op_a_sel_o     (ex_op_a_sel),
    .ex_op_b_sel_o     (ex_op_b_sel),
    .ex_rf_we_o        (ex_rf_we),
    .ex_wb_sel_o       (ex_wb_sel),
    .ex_lsu_req_o      (ex_lsu_req),
    .ex_lsu_we_o       (ex_lsu_we),
    .ex_lsu_type_o     (ex_lsu_type),
    .ex_lsu_sign_ext_o (ex_lsu_sign_ext),
    .ex_branch_o       (ex_branch),
    .ex_jump_o         (ex_jump),
    .ex_illegal_o      (ex_illegal),
    .ex_ecall_o        (ex_ecall),
    .ex_ebreak_o       (ex_ebreak)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Register file model, async read
  assign rf_rdata_a = 32'hA5A5_0000 + 32'(rf_raddr_a);
  assign rf_rdata_b = 32'hA5A5_0000 + 32'(rf_raddr_b);

  // Transfer to EX happens at the next rising edge
  always @(negedge clk) begin
    if (rst_n && ex_valid && ex_ready) seen_pc.push_back(ex_pc);
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic check_op_a(input string name, input op_a_sel_e exp, input op_a_sel_e act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic check_op_b(input string name, input op_b_sel_e exp, input op_b_sel_e act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic check_wb(input string name, input wb_sel_e exp, input wb_sel_e act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic check_lsu(input string name, input lsu_type_e exp, input lsu_type_e act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Encoders and reference values from the ISA
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // funct3 of the register and immediate ALU operations
  function automatic logic [2:0] alu_funct3(input alu_op_e op);
    case (op)
      ALU_SLL:  return 3'd1;
      ALU_SLT:  return 3'd2;
      ALU_SLTU: return 3'd3;
      ALU_XOR:  return 3'd4;
      ALU_SRL,
      ALU_SRA:  return 3'd5;
      ALU_OR:   return 3'd6;
      ALU_AND:  return 3'd7;
      default:  return 3'd0;
    endcase
  endfunction

  function automatic logic [31:0] sext_i(input logic [31:0] word);
    return {{20{word[31]}}, word[31:20]};
  endfunction

  function automatic logic [31:0] rnd_word();
    return $urandom();
  endfunction

  function automatic logic [4:0] rnd_reg();
    logic [31:0] r;
    r = $urandom();
    return r[4:0];
  endfunction

  // Default control of a plain register-register ADD without write
  function automatic id_ctrl_t base_ctrl();
    id_ctrl_t c;
    c              = '0;
    c.alu_op       = ALU_ADD;
    c.op_a_sel     = OP_A_REG;
    c.op_b_sel     = OP_B_REG;
    c.wb_sel       = WB_ALU;
    c.lsu_type     = LSU_WORD;
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  // Holds valid until the transfer edge, leaves valid high
  task automatic send(input logic [31:0] word, input logic [31:0] addr);
    logic took;
    instr_valid = 1'b1;
    instr       = word;
    pc          = addr;
    do begin
      @(negedge clk);
      check_word("rf_raddr_a_o", 32'(word[19:15]), 32'(rf_raddr_a));
      check_word("rf_raddr_b_o", 32'(word[24:20]), 32'(rf_raddr_b));
      took = instr_ready;
      step();
    end while (!took);
  endtask

  // One instruction in, one cycle later checked on the EX side
  task automatic run_one(input logic [31:0] word, input logic [31:0] addr,
                         input id_ctrl_t exp, input logic [31:0] exp_imm);
    send(word, addr);
    instr_valid = 1'b0;
    @(negedge clk);
    check_bit("ex_valid_o", 1'b1, ex_valid);
    check_alu("ex_alu_op_o", exp.alu_op, ex_alu_op);
    check_op_a("ex_op_a_sel_o", exp.op_a_sel, ex_op_a_sel);
    check_op_b("ex_op_b_sel_o", exp.op_b_sel, ex_op_b_sel);
    check_bit("ex_rf_we_o", exp.rf_we, ex_rf_we);
    check_wb("ex_wb_sel_o", exp.wb_sel, ex_wb_sel);
    check_bit("ex_lsu_req_o", exp.lsu_req, ex_lsu_req);
    check_bit("ex_lsu_we_o", exp.lsu_we, ex_lsu_we);
    check_lsu("ex_lsu_type_o", exp.lsu_type, ex_lsu_type);
    check_bit("ex_lsu_sign_ext_o", exp.lsu_sign_ext, ex_lsu_sign_ext);
    check_bit("ex_branch_o", exp.branch, ex_branch);
    check_bit("ex_jump_o", exp.jump, ex_jump);
    check_bit("ex_illegal_o", exp.illegal, ex_illegal);
    check_bit("ex_ecall_o", exp.ecall, ex_ecall);
    check_bit("ex_ebreak_o", exp.ebreak, ex_ebreak);
    check_word("ex_imm_o", exp_imm, ex_imm);
    check_word("ex_rd_o", 32'(word[11:7]), 32'(ex_rd));
    check_word("ex_rs1_data_o", 32'hA5A5_0000 + 32'(word[19:15]), ex_rs1_data);
    check_word("ex_rs2_data_o", 32'hA5A5_0000 + 32'(word[24:20]), ex_rs2_data);
    check_word("ex_pc_o", addr, ex_pc);
    step();
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_tests++;
      $display("PASS %s", name);
    end else begin
      fail_tests++;
      $display("FAIL %s with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = err_cnt;
    @(negedge clk);
    check_bit("ex_valid_o", 1'b0, ex_valid);
    check_bit("ex_rf_we_o", 1'b0, ex_rf_we);
    check_bit("ex_lsu_req_o", 1'b0, ex_lsu_req);
    check_bit("instr_ready_o", 1'b1, instr_ready);
    step();
    end_test("reset", e);
  endtask

  task automatic test_alu();
    int         e;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] sh;
    alu_op_e    op;
    id_ctrl_t   c;
    logic [31:0] w;
    e = err_cnt;
    for (int k = 0; k < 19; k++) begin
      w  = rnd_word();
      sh = w[24:20];
      case (k)
        0, 10:   op = ALU_ADD;
        1:       op = ALU_SUB;
        2, 16:   op = ALU_SLL;   // Shifts by constant from 16 on
        3, 11:   op = ALU_SLT;
        4, 12:   op = ALU_SLTU;
        5, 13:   op = ALU_XOR;
        6, 17:   op = ALU_SRL;
        8, 14:   op = ALU_OR;
        9, 15:   op = ALU_AND;
        default: op = ALU_SRA;
      endcase
      f3 = alu_funct3(op);
      f7 = (op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00;
      if (k >= 10 && k <= 15) begin
        f7 = w[31:25];   // Random upper immediate bits
      end
      c        = base_ctrl();
      c.alu_op = op;
      c.rf_we  = 1'b1;
      if (k >= 10) begin
        c.op_b_sel = OP_B_IMM;
        w = enc_r(f7, sh, rnd_reg(), f3, rnd_reg(), OPC_OP_IMM);
      end else begin
        w = enc_r(f7, rnd_reg(), rnd_reg(), f3, rnd_reg(), OPC_OP);
      end
      run_one(w, rnd_word() & 32'hFFFF_FFFC, c, sext_i(w));
    end
    end_test("alu", e);
  endtask

  task automatic test_mem();
    int          e;
    logic [2:0]  f3;
    logic [11:0] imm;
    id_ctrl_t    c;
    logic [31:0] w;
    e = err_cnt;
    // LB LH LW LBU LHU
    for (int k = 0; k < 5; k++) begin
      f3  = (k < 3) ? 3'(k) : 3'(k + 1);
      imm = 12'(rnd_word());
      c   = base_ctrl();
      c.op_b_sel     = OP_B_IMM;
      c.rf_we        = 1'b1;
      c.wb_sel       = WB_LSU;
      c.lsu_req      = 1'b1;
      c.lsu_type     = (k == 0 || k == 3) ? LSU_BYTE : ((k == 2) ? LSU_WORD : LSU_HALF);
      c.lsu_sign_ext = (k < 3);
      w = {imm, rnd_reg(), f3, rnd_reg(), OPC_LOAD};
      run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {{20{imm[11]}}, imm});
    end
    // SB SH SW
    for (int k = 0; k < 3; k++) begin
      imm = 12'(rnd_word());
      c   = base_ctrl();
      c.op_b_sel = OP_B_IMM;
      c.lsu_req  = 1'b1;
      c.lsu_we   = 1'b1;
      c.lsu_type = (k == 0) ? LSU_BYTE : ((k == 1) ? LSU_HALF : LSU_WORD);
      w = enc_s(imm, rnd_reg(), rnd_reg(), 3'(k));
      run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {{20{imm[11]}}, imm});
    end
    end_test("load_store", e);
  endtask

  task automatic test_flow();
    int          e;
    logic [12:0] bimm;
    logic [20:0] jimm;
    logic [31:0] w;
    logic [31:0] r;
    id_ctrl_t    c;
    e = err_cnt;
    // BEQ BNE BLT BGE BLTU BGEU
    for (int k = 0; k < 6; k++) begin
      r    = rnd_word();
      bimm = {r[12:1], 1'b0};
      c    = base_ctrl();
      c.branch = 1'b1;
      case (k)
        0: c.alu_op = ALU_EQ;
        1: c.alu_op = ALU_NE;
        2: c.alu_op = ALU_LT;
        3: c.alu_op = ALU_GE;
        4: c.alu_op = ALU_LTU;
        default: c.alu_op = ALU_GEU;
      endcase
      w = enc_b(bimm, rnd_reg(), rnd_reg(), (k < 2) ? 3'(k) : 3'(k + 2));
      run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {{19{bimm[12]}}, bimm});
    end
    r    = rnd_word();
    jimm = {r[20:1], 1'b0};
    c = base_ctrl();
    c.op_a_sel = OP_A_PC;
    c.op_b_sel = OP_B_IMM;
    c.rf_we    = 1'b1;
    c.wb_sel   = WB_PC4;
    c.jump     = 1'b1;
    w = enc_j(jimm, rnd_reg());
    run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {{11{jimm[20]}}, jimm});
    c.op_a_sel = OP_A_REG;   // JALR
    w = {12'(rnd_word()), rnd_reg(), 3'b000, rnd_reg(), OPC_JALR};
    run_one(w, rnd_word() & 32'hFFFF_FFFC, c, sext_i(w));
    c = base_ctrl();
    c.op_a_sel = OP_A_ZERO;
    c.op_b_sel = OP_B_IMM;
    c.rf_we    = 1'b1;
    r = rnd_word();
    w = {r[31:12], rnd_reg(), OPC_LUI};
    run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {r[31:12], 12'b0});
    c.op_a_sel = OP_A_PC;
    w = {r[31:12], rnd_reg(), OPC_AUIPC};
    run_one(w, rnd_word() & 32'hFFFF_FFFC, c, {r[31:12], 12'b0});
    end_test("branch_jump_upper", e);
  endtask

  task automatic test_except();
    int          e;
    logic [31:0] w;
    id_ctrl_t    c;
    e = err_cnt;
    c = base_ctrl();
    c.illegal = 1'b1;
    w = {rnd_word() & 32'hFFFF_FF80} | 32'h7F;   // Reserved opcode
    run_one(w, 32'h0000_0400, c, sext_i(w));
    w = enc_r(7'b0000001, rnd_reg(), rnd_reg(), 3'd0, rnd_reg(), OPC_OP);
    run_one(w, 32'h0000_0404, c, sext_i(w));
    c = base_ctrl();
    c.ecall = 1'b1;
    run_one(32'h0000_0073, 32'h0000_0408, c, 32'h0);
    c = base_ctrl();
    c.ebreak = 1'b1;
    run_one(32'h0010_0073, 32'h0000_040C, c, 32'h1);
    end_test("illegal_system", e);
  endtask

  task automatic test_stall();
    int          e;
    int          waited;
    logic [31:0] hold_pc;
    logic [31:0] hold_imm;
    logic [4:0]  hold_rd;
    e = err_cnt;
    seen_pc.delete();
    ex_ready = 1'b0;
    fork
      begin
        for (int k = 0; k < 4; k++) begin
          send({12'(k + 1), 5'd1, 3'b000, 5'(k + 2), OPC_OP_IMM}, 32'h0000_0800 + 32'(4 * k));
        end
        instr_valid = 1'b0;
      end
      begin
        do @(negedge clk); while (!ex_valid);
        hold_pc  = ex_pc;
        hold_imm = ex_imm;
        hold_rd  = ex_rd;
        repeat (5) begin
          @(negedge clk);
          check_bit("ex_valid_o", 1'b1, ex_valid);
          check_bit("instr_ready_o", 1'b0, instr_ready);
          check_word("ex_pc_o", hold_pc, ex_pc);
          check_word("ex_imm_o", hold_imm, ex_imm);
          check_word("ex_rd_o", 32'(hold_rd), 32'(ex_rd));
        end
        step();
        ex_ready = 1'b1;
      end
    join
    waited = 0;
    while (seen_pc.size() < 4 && waited < 50) begin
      step();
      waited++;
    end
    repeat (4) step();   // Nothing extra may leave
    if (seen_pc.size() != 4) begin
      $display("Stall test saw %0d instructions leave the stage instead of 4", seen_pc.size());
      err_cnt++;
    end else begin
      for (int k = 0; k < 4; k++) begin
        check_word("ex_pc_o order", 32'h0000_0800 + 32'(4 * k), seen_pc[k]);
      end
    end
    end_test("back_pressure", e);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    #(NumTests * 200 * 4);
    $display("Timeout, the tests did not finish in the allowed time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h6626b0ac));
    err_cnt     = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = `ID_NOP_INSTR;
    pc          = '0;
    ex_ready    = 1'b1;
    repeat (3) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    test_reset();
    test_alu();
    test_mem();
    test_flow();
    test_except();
    test_stall();
    $display("Tests passed %0d failed %0d, %0d errors", pass_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
rv_isa_pkg.sv
id_ctrl_pkg.sv
id_dec_if.sv
id_decoder.sv
id_imm_gen.sv
id_ex_pipe.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sources.f --top-module tb_id_stage -o Vtb_id_stage

run: build
	./obj_dir/Vtb_id_stage | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No result in log"; exit 1)

lint:
	verilator --lint-only -Wall -f sources.f --top-module id_stage

clean:
	rm -rf obj_dir $(LOG)
